//--- sim.f
hw/lv_pkg.sv
hw/lv_ctrl_fsm.sv
hw/lv_reg_access.sv
hw/lv_reg_slice.sv
hw/lv_rdata_merge.sv
hw/lv_ctrl_top.sv
bench/lv_ctrl_checker.sv
bench/tb_lv_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_lv_ctrl -f sim.f -o tb_lv_ctrl \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_lv_ctrl > sim.log 2>&1
status=$?
cat sim.log

# the fail message in the log decides the result
grep -q "sim failed" sim.log && { echo "run FAILED"; exit 1; }
[ "$status" -eq 0 ] || { echo "simulator exited with status $status"; exit 1; }
grep -q "sim passed" sim.log || { echo "run ended without a result line"; exit 1; }
echo "run PASSED"
exit 0

//--- bench/tb_lv_ctrl.sv
// random stimulus seeded with 32'ha8eb; the model covers NUM_REGS entries of the package table
`default_nettype none

module tb_lv_ctrl;

    import lv_pkg::*;

    localparam int NUM_REGS = 8;
    localparam int RST_CYC  = 8;
    localparam int N_FUSE   = 24;
    localparam int N_RAND   = 300;
    localparam int N_B2B    = 40;
    localparam int N_FAULT  = 40;
    // test lengths with their fixed overhead, then slack
    localparam int MAX_CYC  = RST_CYC + N_FUSE + 2 * N_RAND + 2 * N_B2B + N_FAULT + 164;

    logic     clk;
    logic     rst_n;
    logic     chk_en;
    logic     bus_wen;
    logic     bus_ren;
    addr_t    bus_addr;
    data_t    bus_wdata;
    crc_t     bus_wcrc;
    logic     pwr_on;
    logic     test_mode;
    logic     fuse_vld;
    addr_t    fuse_addr;
    data_t    fuse_data;
    logic     fuse_done;
    logic     ow_com_err;
    logic     ow_wdg_err;
    logic     spi_err;
    logic     rvld;
    data_t    rdata;
    crc_t     rcrc;
    logic     acc_err;
    lv_mode_e mode;
    logic     fsenb_n;
    reg_req_t req_probe;
    // model state and predictions
    data_t    m_data [NUM_REGS];
    crc_t     m_crc [NUM_REGS];
    lv_mode_e m_mode;
    logic     exp_rvld;
    data_t    exp_rdata;
    crc_t     exp_rcrc;
    logic     exp_acc_err;
    int       cyc_cnt = 0;

    lv_ctrl_top #(
        .NUM_REGS (NUM_REGS)
    ) uut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_bus_wen    (bus_wen),
        .i_bus_ren    (bus_ren),
        .i_bus_addr   (bus_addr),
        .i_bus_wdata  (bus_wdata),
        .i_bus_wcrc   (bus_wcrc),
        .i_pwr_on     (pwr_on),
        .i_test_mode  (test_mode),
        .i_fuse_vld   (fuse_vld),
        .i_fuse_addr  (fuse_addr),
        .i_fuse_data  (fuse_data),
        .i_fuse_done  (fuse_done),
        .i_ow_com_err (ow_com_err),
        .i_ow_wdg_err (ow_wdg_err),
        .i_spi_err    (spi_err),
        .o_rvld       (rvld),
        .o_rdata      (rdata),
        .o_rcrc       (rcrc),
        .o_acc_err    (acc_err),
        .o_mode       (mode),
        .o_fsenb_n    (fsenb_n)
    );

    // bank request, for the strobe overlap rule
    assign req_probe = uut.req;

    lv_ctrl_checker u_chk (
        .i_clk         (clk),
        .i_en          (chk_en),
        .i_req         (req_probe),
        .i_rvld        (rvld),
        .i_rdata       (rdata),
        .i_rcrc        (rcrc),
        .i_acc_err     (acc_err),
        .i_mode        (mode),
        .i_fsenb_n     (fsenb_n),
        .i_exp_rvld    (exp_rvld),
        .i_exp_rdata   (exp_rdata),
        .i_exp_rcrc    (exp_rcrc),
        .i_exp_acc_err (exp_acc_err),
        .i_exp_mode    (m_mode),
        .i_exp_fsenb_n (m_mode != LV_FUSE_LOAD)
    );

    // ====================
    // clock and watchdog
    // ====================
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    initial begin
        wait (cyc_cnt >= MAX_CYC);
        $display("timeout: run did not finish within %0d cycles", MAX_CYC);
        $display("sim failed");
        $finish;
    end

    // ====================
    // model
    // ====================
    function automatic int find_idx(input addr_t addr);
        int idx;
        idx = -1;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (REG_ATTR[i].addr == addr) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // applies the inputs that were live at the last rising edge
    task automatic model_step();
        int       idx;
        logic     wr_ok;
        logic     rd_ok;
        lv_mode_e nxt;
        exp_rvld    = 1'b0;
        exp_acc_err = 1'b0;
        wr_ok       = 1'b0;
        rd_ok       = 1'b0;
        if (m_mode == LV_FUSE_LOAD) begin
            // fuse words ignore permissions and clear the tag
            idx = find_idx(fuse_addr);
            if (fuse_vld && idx >= 0) begin
                m_data[idx] = fuse_data;
                m_crc[idx]  = '0;
            end
        end else if (m_mode == LV_CFG || m_mode == LV_TEST) begin
            idx = find_idx(bus_addr);
            if (idx >= 0) begin
                wr_ok = (m_mode == LV_TEST) ? REG_ATTR[idx].test_wr : REG_ATTR[idx].cfg_wr;
                rd_ok = (m_mode == LV_TEST) ? REG_ATTR[idx].test_rd : REG_ATTR[idx].cfg_rd;
            end
            // write wins over a read in the same cycle
            if (bus_wen) begin
                if (wr_ok) begin
                    m_data[idx] = bus_wdata;
                    m_crc[idx]  = bus_wcrc;
                end else begin
                    exp_acc_err = 1'b1;
                end
            end else if (bus_ren) begin
                if (rd_ok) begin
                    exp_rvld  = 1'b1;
                    exp_rdata = m_data[idx];
                    exp_rcrc  = m_crc[idx];
                end else begin
                    exp_acc_err = 1'b1;
                end
            end
        end
        // sequencer
        nxt = m_mode;
        if (!pwr_on) begin
            nxt = LV_OFF;
        end else begin
            case (m_mode)
                LV_OFF:       nxt = LV_FUSE_LOAD;
                LV_FUSE_LOAD: nxt = fuse_done ? LV_CFG : LV_FUSE_LOAD;
                LV_CFG, LV_TEST: begin
                    if (ow_com_err || ow_wdg_err || spi_err) begin
                        nxt = LV_FAULT;
                    end else begin
                        nxt = test_mode ? LV_TEST : LV_CFG;
                    end
                end
                default:      nxt = m_mode;
            endcase
        end
        m_mode = nxt;
    endtask

    // ====================
    // stimulus helpers
    // ====================
    task automatic step_cycle();
        @(negedge clk);
        model_step();
    endtask

    // mostly mapped addresses, a quarter anywhere
    function automatic addr_t rand_addr();
        int idx;
        idx = $urandom % NUM_REGS;
        if ($urandom % 4 == 0) begin
            return addr_t'($urandom);
        end
        return REG_ATTR[idx].addr;
    endfunction

    task automatic bus_access(input logic wen, input logic ren, input addr_t addr);
        step_cycle();
        bus_wen   = wen;
        bus_ren   = ren;
        bus_addr  = addr;
        bus_wdata = data_t'($urandom);
        bus_wcrc  = crc_t'($urandom);
    endtask

    task automatic rand_access();
        logic wr;
        wr = ($urandom % 4) < 2;
        bus_access(wr, ~wr, rand_addr());
    endtask

    // ====================
    // tests
    // ====================
    task automatic power_up_seq();
        u_chk.start_test("reset_powerup");
        // off mode drops every read silently
        for (int i = 0; i < NUM_REGS; i++) begin
            bus_access(1'b0, 1'b1, REG_ATTR[i].addr);
        end
        step_cycle();
        bus_ren = 1'b0;
        pwr_on  = 1'b1;
        // fuse words, bus noise must be dropped
        for (int i = 0; i < N_FUSE; i++) begin
            bus_access(($urandom % 2) == 1, ($urandom % 2) == 1, rand_addr());
            fuse_vld  = ($urandom % 4) != 0;
            fuse_addr = rand_addr();
            fuse_data = data_t'($urandom);
        end
        bus_access(1'b0, 1'b0, '0);
        fuse_vld  = 1'b0;
        fuse_done = 1'b1;
        step_cycle();
        fuse_done = 1'b0;
        step_cycle();
        u_chk.end_test();
    endtask

    task automatic cfg_random_access();
        u_chk.start_test("cfg_access");
        for (int i = 0; i < N_RAND; i++) begin
            rand_access();
        end
        bus_access(1'b0, 1'b0, '0);
        test_mode = 1'b1;
        u_chk.end_test();
    endtask

    task automatic test_random_access();
        u_chk.start_test("test_access");
        for (int i = 0; i < N_RAND; i++) begin
            rand_access();
            // occasional trip back through cfg mode
            if (i % 60 == 59) begin
                test_mode = ~test_mode;
            end
        end
        test_mode = 1'b0;
        bus_access(1'b0, 1'b0, '0);
        bus_access(1'b0, 1'b0, '0);
        u_chk.end_test();
    endtask

    task automatic priority_and_b2b();
        u_chk.start_test("write_priority_b2b");
        for (int i = 0; i < N_B2B; i++) begin
            bus_access(1'b1, 1'b1, rand_addr());
        end
        // one read per cycle, walking the table
        for (int i = 0; i < N_B2B; i++) begin
            bus_access(1'b0, 1'b1, REG_ATTR[i % NUM_REGS].addr);
        end
        bus_access(1'b0, 1'b0, '0);
        u_chk.end_test();
    endtask

    task automatic fault_recovery();
        int pick;
        u_chk.start_test("fault_handling");
        for (int i = 0; i < NUM_REGS; i++) begin
            bus_access(1'b1, 1'b0, REG_ATTR[i].addr);
        end
        bus_access(1'b0, 1'b0, '0);
        pick       = $urandom % 3;
        ow_com_err = (pick == 0);
        ow_wdg_err = (pick == 1);
        spi_err    = (pick == 2);
        step_cycle();
        ow_com_err = 1'b0;
        ow_wdg_err = 1'b0;
        spi_err    = 1'b0;
        // fault latched, bus and test mode have no effect
        for (int i = 0; i < N_FAULT; i++) begin
            rand_access();
            test_mode = ($urandom % 2) == 1;
        end
        bus_access(1'b0, 1'b0, '0);
        test_mode = 1'b0;
        pwr_on    = 1'b0;
        step_cycle();
        pwr_on = 1'b1;
        step_cycle();
        fuse_done = 1'b1;
        step_cycle();
        fuse_done = 1'b0;
        // contents must have survived, cfg then test view
        for (int i = 0; i < NUM_REGS; i++) begin
            bus_access(1'b0, 1'b1, REG_ATTR[i].addr);
        end
        bus_access(1'b0, 1'b0, '0);
        test_mode = 1'b1;
        for (int i = 0; i < NUM_REGS; i++) begin
            bus_access(1'b0, 1'b1, REG_ATTR[i].addr);
        end
        bus_access(1'b0, 1'b0, '0);
        bus_access(1'b0, 1'b0, '0);
        u_chk.end_test();
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        void'($urandom(32'ha8eb));
        rst_n      = 1'b0;
        chk_en     = 1'b0;
        bus_wen    = 1'b0;
        bus_ren    = 1'b0;
        bus_addr   = '0;
        bus_wdata  = '0;
        bus_wcrc   = '0;
        pwr_on     = 1'b0;
        test_mode  = 1'b0;
        fuse_vld   = 1'b0;
        fuse_addr  = '0;
        fuse_data  = '0;
        fuse_done  = 1'b0;
        ow_com_err = 1'b0;
        ow_wdg_err = 1'b0;
        spi_err    = 1'b0;
        // model starts from the reset image
        for (int i = 0; i < NUM_REGS; i++) begin
            m_data[i] = REG_ATTR[i].dflt;
            m_crc[i]  = '0;
        end
        m_mode      = LV_OFF;
        exp_rvld    = 1'b0;
        exp_rdata   = '0;
        exp_rcrc    = '0;
        exp_acc_err = 1'b0;
        repeat (RST_CYC) @(negedge clk);
        rst_n  = 1'b1;
        chk_en = 1'b1;
        power_up_seq();
        cfg_random_access();
        test_random_access();
        priority_and_b2b();
        fault_recovery();
        u_chk.report_totals();
        if (u_chk.err_total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/lv_ctrl_checker.sv
// samples on the rising edge; rdata and rcrc are compared only when a response is expected
`default_nettype none

module lv_ctrl_checker (
    input  logic             i_clk,
    input  logic             i_en,
    // request seen by the register bank
    input  lv_pkg::reg_req_t i_req,
    // DUT outputs
    input  logic             i_rvld,
    input  lv_pkg::data_t    i_rdata,
    input  lv_pkg::crc_t     i_rcrc,
    input  logic             i_acc_err,
    input  lv_pkg::lv_mode_e i_mode,
    input  logic             i_fsenb_n,
    // model predictions
    input  logic             i_exp_rvld,
    input  lv_pkg::data_t    i_exp_rdata,
    input  lv_pkg::crc_t     i_exp_rcrc,
    input  logic             i_exp_acc_err,
    input  lv_pkg::lv_mode_e i_exp_mode,
    input  logic             i_exp_fsenb_n
);

    import lv_pkg::*;

    string cur_test = "idle";
    int    test_checks = 0;
    int    test_errs = 0;
    int    n_pass = 0;
    int    n_fail = 0;
    int    err_total = 0;

    // ====================
    // test bookkeeping
    // ====================
    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
    endtask

    task automatic report_totals();
        $display("totals: %0d tests ok, %0d tests bad, %0d errors", n_pass, n_fail, err_total);
    endtask

    // one value against its prediction, X counts as a mismatch
    task automatic compare(input string what, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
        test_checks++;
        if (act_val !== exp_val) begin
            test_errs++;
            err_total++;
            $display("[ERROR] %s %s: expected %h actual %h", cur_test, what, exp_val, act_val);
        end
    endtask

    // ====================
    // per cycle compare
    // ====================
    always @(posedge i_clk) begin
        if (i_en) begin
            compare("mode", 32'(i_exp_mode), 32'(i_mode));
            compare("fsenb_n", 32'(i_exp_fsenb_n), 32'(i_fsenb_n));
            compare("rvld", 32'(i_exp_rvld), 32'(i_rvld));
            compare("acc_err", 32'(i_exp_acc_err), 32'(i_acc_err));
            // payload is undefined without a response
            if (i_exp_rvld) begin
                compare("rdata", 32'(i_exp_rdata), 32'(i_rdata));
                compare("rcrc", 32'(i_exp_rcrc), 32'(i_rcrc))
                ;
            end
            // front end must never let both strobes through
            if (i_req.wen && i_req.ren) begin
                test_errs++;
                err_total++;
                $display("test %s: write and read strobes reached the register bank together",
                         cur_test);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lv_ctrl_top.sv
// NUM_REGS must stay within the package table; no back-pressure, one request per cycle
`default_nettype none

module lv_ctrl_top #(
    parameter int NUM_REGS = 8
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    // bus master
    input  logic             i_bus_wen,
    input  logic             i_bus_ren,
    input  lv_pkg::addr_t    i_bus_addr,
    input  lv_pkg::data_t    i_bus_wdata,
    input  lv_pkg::crc_t     i_bus_wcrc,
    // power and mode
    input  logic             i_pwr_on,
    input  logic             i_test_mode,
    // fuse loader
    input  logic             i_fuse_vld,
    input  lv_pkg::addr_t    i_fuse_addr,
    input  lv_pkg::data_t    i_fuse_data,
    input  logic             i_fuse_done,
    // link errors
    input  logic             i_ow_com_err,
    input  logic             i_ow_wdg_err,
    input  logic             i_spi_err,
    // read response and status
    output logic             o_rvld,
    output lv_pkg::data_t    o_rdata,
    output lv_pkg::crc_t     o_rcrc,
    output logic             o_acc_err,
    output lv_pkg::lv_mode_e o_mode,
    output logic             o_fsenb_n
);

    import lv_pkg::*;

    lv_mode_e                   mode;
    reg_req_t                   req;
    slice_rsp_t [NUM_REGS-1:0]  rsp;

    // ====================
    // sequencer
    // ====================
    lv_ctrl_fsm u_fsm (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_pwr_on     (i_pwr_on),
        .i_test_mode  (i_test_mode),
        .i_fuse_done  (i_fuse_done),
        .i_ow_com_err (i_ow_com_err),
        .i_ow_wdg_err (i_ow_wdg_err),
        .i_spi_err    (i_spi_err),
        .o_mode       (mode),
        .o_fsenb_n    (o_fsenb_n)
    );

    // request front end
    lv_reg_access u_access (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_mode      (mode),
        .i_bus_wen   (i_bus_wen),
        .i_bus_ren   (i_bus_ren),
        .i_bus_addr  (i_bus_addr),
        .i_bus_wdata (i_bus_wdata),
        .i_bus_wcrc  (i_bus_wcrc),
        .i_fuse_vld  (i_fuse_vld),
        .i_fuse_addr (i_fuse_addr),
        .i_fuse_data (i_fuse_data),
        .o_req       (req)
    );

    // ====================
    // register bank
    // ====================
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_slice
        lv_reg_slice #(
            .IDX (i)
        ) u_slice (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_req   (req),
            .o_rsp   (rsp[i])
        );
    end

    // read return and error flag
    lv_rdata_merge #(
        .NUM_REGS (NUM_REGS)
    ) u_merge (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_req     (req),
        .i_rsp     (rsp),
        .o_rvld    (o_rvld),
        .o_rdata   (o_rdata),
        .o_rcrc    (o_rcrc),
        .o_acc_err (o_acc_err)
    );

    assign o_mode = mode;

endmodule

`default_nettype wire

//--- hw/lv_rdata_merge.sv
// relies on slices zeroing ungranted data; response and error appear one cycle after the strobe
`default_nettype none

module lv_rdata_merge #(
    parameter int NUM_REGS = 8
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  lv_pkg::reg_req_t                  i_req,
    input  lv_pkg::slice_rsp_t [NUM_REGS-1:0] i_rsp,
    output logic                              o_rvld,
    output lv_pkg::data_t                     o_rdata,
    output lv_pkg::crc_t                      o_rcrc,
    output logic                              o_acc_err
);

    import lv_pkg::*;

    logic  any_wgnt;
    logic  any_rgnt;
    data_t rdata_or;
    crc_t  rcrc_or;
    logic  miss;
    logic  rvld_q;
    logic  acc_err_q;
    data_t rdata_q;
    crc_t  rcrc_q;

    // ====================
    // OR reduction
    // ====================
    always_comb begin
        any_wgnt = 1'b0;
        any_rgnt = 1'b0;
        rdata_or = '0;
        rcrc_or  = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            any_wgnt = any_wgnt | i_rsp[i].wgnt;
            any_rgnt = any_rgnt | i_rsp[i].rgnt;
            rdata_or = rdata_or | i_rsp[i].rdata;
            rcrc_or  = rcrc_or | i_rsp[i].rcrc;
        end
    end

    // bus strobe nobody took
    assign miss = (i_req.wen | i_req.ren) & ~i_req.fuse & ~(any_wgnt | any_rgnt);

    // control flags
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rvld_q    <= 1'b0;
            acc_err_q <= 1'b0;
        end else begin
            rvld_q    <= any_rgnt;
            acc_err_q <= miss;
        end
    end

    // response payload
    always_ff @(posedge i_clk) begin
        rdata_q <= rdata_or;
        rcrc_q  <= rcrc_or;
    end

    assign o_rvld    = rvld_q;
    assign o_acc_err = acc_err_q;
    assign o_rdata   = rdata_q;
    assign o_rcrc    = rcrc_q;

endmodule

`default_nettype wire

//--- hw/lv_reg_slice.sv
// IDX selects the attribute table entry; CRC is stored as given and never checked
`default_nettype none

module lv_reg_slice #(
    parameter int IDX = 0
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  lv_pkg::reg_req_t   i_req,
    output lv_pkg::slice_rsp_t o_rsp
);

    import lv_pkg::*;

    localparam reg_attr_t ATTR = REG_ATTR[IDX];

    logic  hit;
    logic  wr_ok;
    logic  rd_ok;
    logic  wgnt;
    logic  rgnt;
    data_t data_q;
    crc_t  crc_q;

    // ====================
    // address and permission
    // ====================
    assign hit = (i_req.addr == ATTR.addr);

    // fuse writes bypass the mode permissions
    assign wr_ok = i_req.fuse
                 | (i_req.test_st & ATTR.test_wr)
                 | (i_req.cfg_st & ATTR.cfg_wr);
    assign rd_ok = (i_req.test_st & ATTR.test_rd) | (i_req.cfg_st & ATTR.cfg_rd);

    assign wgnt = i_req.wen & hit & wr_ok;
    assign rgnt = i_req.ren & hit & rd_ok;

    // word and tag storage
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            data_q <= ATTR.dflt;
            crc_q  <= '0;
        end else if (wgnt) begin
            data_q <= i_req.data;
            crc_q  <= i_req.crc;
        end
    end

    // zeros unless granted so the merge can OR
    assign o_rsp.wgnt  = wgnt;
    assign o_rsp.rgnt  = rgnt;
    assign o_rsp.rdata = rgnt ? data_q : '0;
    assign o_rsp.rcrc  = rgnt ? crc_q : '0;

endmodule

`default_nettype wire

//--- hw/lv_reg_access.sv
// request path is combinational; at most one strobe leaves per cycle, write before read
`default_nettype none

module lv_reg_access (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  lv_pkg::lv_mode_e i_mode,
    // bus master side
    input  logic             i_bus_wen,
    input  logic             i_bus_ren,
    input  lv_pkg::addr_t    i_bus_addr,
    input  lv_pkg::data_t    i_bus_wdata,
    input  lv_pkg::crc_t     i_bus_wcrc,
    // fuse loader side
    input  logic             i_fuse_vld,
    input  lv_pkg::addr_t    i_fuse_addr,
    input  lv_pkg::data_t    i_fuse_data,
    // broadcast to all slices
    output lv_pkg::reg_req_t o_req
);

    import lv_pkg::*;

    reg_req_t req;

    // ====================
    // source select
    // ====================
    always_comb begin
        req = '0;
        case (i_mode)
            LV_FUSE_LOAD: begin
                // bus is ignored while fuses load
                req.wen  = i_fuse_vld;
                req.fuse = i_fuse_vld;
                req.addr = i_fuse_addr;
                req.data = i_fuse_data;
                // fuse words carry no tag
                req.crc  = '0;
            end
            LV_CFG, LV_TEST: begin
                req.wen  = i_bus_wen;
                // read dropped when a write comes with it
                req.ren  = i_bus_ren & ~i_bus_wen;
                req.addr = i_bus_addr;
                req.data = i_bus_wdata;
                req.crc  = i_bus_wcrc;
            end
            default: begin
                // off and fault pass nothing
                req = '0;
            end
        endcase
        // mode status for the permission checks
        req.test_st = (i_mode == LV_TEST);
        req.cfg_st  = (i_mode == LV_CFG);
    end

    assign o_req = req;

endmodule

`default_nettype wire

//--- hw/lv_ctrl_fsm.sv
// power loss overrides every state; link errors are sampled only in cfg and test mode
`default_nettype none

module lv_ctrl_fsm (
    input  logic             i_clk,
    input  logic             i_rst_n,
    // power and mode requests
    input  logic             i_pwr_on,
    input  logic             i_test_mode,
    // fuse loader handshake
    input  logic             i_fuse_done,
    // link error flags
    input  logic             i_ow_com_err,
    input  logic             i_ow_wdg_err,
    input  logic             i_spi_err,
    // current state
    output lv_pkg::lv_mode_e o_mode,
    // low while fuse sensing is on
    output logic             o_fsenb_n
);

    import lv_pkg::*;

    // ====================
    // declarations
    // ====================
    lv_mode_e state_q;
    lv_mode_e state_d;
    logic     link_err;

    // any link fault counts the same
    assign link_err = i_ow_com_err | i_ow_wdg_err | i_spi_err;

    // ====================
    // next state
    // ====================
    always_comb begin
        state_d = state_q;
        if (!i_pwr_on) begin
            // power drop wins over everything
            state_d = LV_OFF;
        end else begin
            case (state_q)
                LV_OFF: begin
                    // power just came up
                    state_d = LV_FUSE_LOAD;
                end
                LV_FUSE_LOAD: begin
                    // wait for the loader to finish
                    if (i_fuse_done) begin
                        state_d = LV_CFG;
                    end
                end
                LV_CFG: begin
                    if (link_err) begin
                        state_d = LV_FAULT;
                    end else if (i_test_mode) begin
                        state_d = LV_TEST;
                    end
                end
                LV_TEST: begin
                    if (link_err) begin
                        state_d = LV_FAULT;
                    end else if (!i_test_mode) begin
                        state_d = LV_CFG;
                    end
                end
                LV_FAULT: begin
                    // latched until power goes away
                    state_d = LV_FAULT;
                end
                default: begin
                    state_d = LV_OFF;
                end
            endcase
        end
    end

    // ====================
    // state register
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= LV_OFF;
        end else begin
            state_q <= state_d;
        end
    end

    // outputs straight from the state
    assign o_mode = state_q;

    // sense enable only during the load window
    assign o_fsenb_n = (state_q != LV_FUSE_LOAD);

endmodule

`default_nettype wire

//--- hw/lv_pkg.sv
// the attribute table holds 8 entries; addresses in it must be unique and NUM_REGS may not exceed it
`default_nettype none

package lv_pkg;

    // ====================
    // widths
    // ====================
    typedef logic [5:0]  addr_t;
    typedef logic [15:0] data_t;
    typedef logic [7:0]  crc_t;

    // sequencer states
    typedef enum logic [2:0] {
        LV_OFF,
        LV_FUSE_LOAD,
        LV_CFG,
        LV_TEST,
        LV_FAULT
    } lv_mode_e;

    // per register address, reset value and mode permissions
    typedef struct packed {
        addr_t addr;
        data_t dflt;
        logic  test_wr;
        logic  test_rd;
        logic  cfg_wr;
        logic  cfg_rd;
    } reg_attr_t;

    // one request shared by every slice
    typedef struct packed {
        logic  wen;
        logic  ren;
        addr_t addr;
        data_t data;
        crc_t  crc;
        logic  fuse;
        logic  test_st;
        logic  cfg_st;
    } reg_req_t;

    // slice answer, data and tag are zero unless the read is granted
    typedef struct packed {
        logic  wgnt;
        logic  rgnt;
        data_t rdata;
        crc_t  rcrc;
    } slice_rsp_t;

    // ====================
    // attribute table
    // ====================
    localparam int REG_TBL_SIZE = 8;

    localparam reg_attr_t REG_ATTR [REG_TBL_SIZE] = '{
        // addr   default    tw    tr    cw    cr
        '{6'h00, 16'h0a5c, 1'b1, 1'b1, 1'b1, 1'b1},
        '{6'h01, 16'h1234, 1'b0, 1'b1, 1'b1, 1'b1},
        '{6'h02, 16'h00ff, 1'b1, 1'b1, 1'b0, 1'b1},
        '{6'h04, 16'hc3c3, 1'b0, 1'b0, 1'b1, 1'b1},
        '{6'h08, 16'h8001, 1'b1, 1'b0, 1'b1, 1'b0},
        '{6'h10, 16'h5aa5, 1'b0, 1'b1, 1'b0, 1'b0},
        '{6'h20, 16'h7e00, 1'b1, 1'b1, 1'b0, 1'b0},
        '{6'h3f, 16'hdead, 1'b0, 1'b0, 1'b0, 1'b1}
    };

endpackage

`default_nettype wire
